// File: hw/fetch_pkg.sv
// fetch front end package with shared widths, the JAL opcode and field positions

package fetch_pkg;

  // datapath widths
  localparam int unsigned INST_WD      = 32;  // one RV64 base instruction
  localparam int unsigned PC_WD        = 64;
  localparam int unsigned SRAM_ADDR_WD = 64;  // byte address into inst sram
  localparam int unsigned SRAM_DATA_WD = 64;  // two instructions per sram word

  // major opcode field
  localparam int unsigned OPC_LSB      = 0;
  localparam logic [6:0]  OPC_JAL      = 7'b1101111;

endpackage

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ns
// fetch control with stage valid flags, the allowin chain and the one-shot JAL redirect

module fetch_ctrl (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_es_allowin,     // execute stage can take the decode inst
  input  logic i_is_jal,         // decode inst is a JAL
  output logic o_pc_load,
  output logic o_fs_valid,
  output logic o_fs_fire,
  output logic o_ds_valid,
  output logic o_redirect
);

  logic running;                 // high from the first edge with reset released
  logic jal_done;                // JAL in decode has already redirected
  logic fs_allowin;
  logic ds_allowin;
  logic ds_leave;

  // allowin chain from back to front
  assign ds_leave   = o_ds_valid && i_es_allowin;
  assign ds_allowin = !o_ds_valid || i_es_allowin;

  // one strobe per JAL even if decode stalls for many cycles
  assign o_redirect = o_ds_valid && i_is_jal && !jal_done;

  // the inst behind a redirecting JAL is on the wrong path and is dropped here
  assign o_fs_fire  = o_fs_valid && ds_allowin && !o_redirect;
  assign fs_allowin = !o_fs_valid || o_fs_fire;

  // redirect reloads the pc even while decode holds the JAL
  assign o_pc_load  = running && (fs_allowin || o_redirect);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  // every fire or redirect refills fetch so it stays full once started
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_fs_valid <= 1'b0;
    end else if (o_pc_load) begin
      o_fs_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      o_ds_valid <= o_fs_fire;   // empty after a cancelled fetch
    end
  end

  // leaving decode wins over setting so the next inst starts clean
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      jal_done <= 1'b0;
    end else if (ds_leave) begin
      jal_done <= 1'b0;
    end else if (o_redirect) begin
      jal_done <= 1'b1;
    end
  end

  a_redirect_one_shot: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_redirect |=> !o_redirect
  ) else $error("redirect high in two consecutive cycles");

  // decode only fills from fetch and fetch never drains
  a_fs_full_behind_ds: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_ds_valid |-> o_fs_valid
  ) else $error("decode valid while the fetch stage is empty");

endmodule

// File: hw/fetch_pc.sv
`timescale 1ns/1ns
// pc generator, with the pc register, next pc selection and the inst sram read request

module fetch_pc import fetch_pkg::*; #(
  parameter logic [PC_WD-1:0] PC_RESETVAL = 64'h8000_0000
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_load,          // take next pc and read sram
  input  logic                    i_redirect,      // JAL resolved in decode
  input  logic [PC_WD-1:0]        i_jal_target,
  output logic [PC_WD-1:0]        o_pc,            // pc of the fetch stage
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic             first_load;    // no pc fetched yet since reset
  logic [PC_WD-1:0] pc_next;

  always_comb begin
    if (first_load) begin
      pc_next = PC_RESETVAL;
    end else if (i_redirect) begin
      pc_next = i_jal_target;
    end else begin
      pc_next = o_pc + PC_WD'(4);
    end
  end

  // sram is read in the load cycle, data comes back with the new pc
  assign o_inst_sram_ren  = i_load;
  assign o_inst_sram_addr = {pc_next[SRAM_ADDR_WD-1:3], 3'b000};  // 64-bit word address

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      first_load <= 1'b1;
    end else if (i_load) begin
      first_load <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_pc <= PC_RESETVAL;
    end else if (i_load) begin
      o_pc <= pc_next;
    end
  end

  // catches misaligned jump targets as well as a bad reset value
  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_pc[1:0] == 2'b00
  ) else $error("fetch pc not aligned to 4 bytes: %h", o_pc);

endmodule

// File: hw/fetch_inst_align.sv
`timescale 1ns/1ns
// instruction align, which picks the 32-bit half by pc[2] and holds it while fetch stalls

module fetch_inst_align import fetch_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_pc_load,          // sram read issued this cycle
  input  logic                    i_pc_align,         // pc[2] of the fetch stage
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  output logic [INST_WD-1:0]      o_inst
);

  logic               fresh;      // rdata belongs to the current fetch pc
  logic [INST_WD-1:0] half;
  logic [INST_WD-1:0] hold_inst;  // copy for stalled cycles

  // upper half for pc[2] set, lower half otherwise
  assign half = i_pc_align ? i_inst_sram_rdata[SRAM_DATA_WD-1 -: INST_WD]
                           : i_inst_sram_rdata[INST_WD-1:0];

  // sram data is only good in the cycle right after the read
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fresh <= 1'b0;
    end else begin
      fresh <= i_pc_load;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fresh) begin
      hold_inst <= half;
    end
  end

  assign o_inst = fresh ? half : hold_inst;  // direct path keeps fetch at one cycle

endmodule

// File: hw/fetch_ds_reg.sv
`timescale 1ns/1ns
// decode stage register, which holds the pc and instruction handed over by fetch

module fetch_ds_reg import fetch_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_fs_fire,   // fetch inst moves into decode
  input  logic [PC_WD-1:0]   i_fs_pc,
  input  logic [INST_WD-1:0] i_fs_inst,
  output logic [PC_WD-1:0]   o_ds_pc,
  output logic [INST_WD-1:0] o_ds_inst
);

  // held unchanged while decode waits on execute
  always_ff @(posedge i_clk) begin
    if (i_fs_fire) begin
      o_ds_pc   <= i_fs_pc;
      o_ds_inst <= i_fs_inst;
    end
  end

  // every pc that enters decode came out of the pc generator aligned
  a_ds_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_fs_fire |=> o_ds_pc[1:0] == 2'b00
  ) else $error("decode pc not aligned to 4 bytes: %h", o_ds_pc);

endmodule

// File: hw/fetch_jal_unit.sv
`timescale 1ns/1ns
// JAL unit, which detects a JAL in decode and computes its J-type jump target

module fetch_jal_unit import fetch_pkg::*; (
  input  logic [PC_WD-1:0]   i_ds_pc,
  input  logic [INST_WD-1:0] i_ds_inst,
  output logic               o_is_jal,
  output logic [PC_WD-1:0]   o_jal_target
);

  logic [$bits(OPC_JAL)-1:0] opcode;
  logic [20:0]               j_imm;      // byte offset, bit 0 always zero
  logic [PC_WD-1:0]          j_imm_sext;

  assign opcode   = i_ds_inst[OPC_LSB +: $bits(OPC_JAL)];
  assign o_is_jal = (opcode == OPC_JAL);

  // J-type immediate is scattered across the instruction
  assign j_imm = {i_ds_inst[31],        // imm[20]
                  i_ds_inst[19:12],     // imm[19:12]
                  i_ds_inst[20],        // imm[11]
                  i_ds_inst[30:21],     // imm[10:1]
                  1'b0};

  assign j_imm_sext = {{(PC_WD-21){j_imm[20]}}, j_imm};

  // pc relative, forward and backward
  assign o_jal_target = i_ds_pc + j_imm_sext;

endmodule

// File: hw/fetch_frontend_top.sv
`timescale 1ns/1ns
// fetch front end top joining pc generator, align, decode register, JAL unit and control

module fetch_frontend_top import fetch_pkg::*; #(
  parameter logic [PC_WD-1:0] PC_RESETVAL = 64'h8000_0000
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // execute stage
  input  logic                    i_es_allowin,
  output logic                    o_ds_valid,
  output logic [PC_WD-1:0]        o_ds_pc,
  output logic [INST_WD-1:0]      o_ds_inst,
  // inst sram read port
  output logic                    o_inst_sram_ren,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic               pc_load;
  logic               fs_fire;
  logic               redirect;
  logic               is_jal;
  logic [PC_WD-1:0]   jal_target;
  logic [PC_WD-1:0]   fs_pc;
  logic [INST_WD-1:0] fs_inst;

  fetch_ctrl u_ctrl (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .i_es_allowin      (i_es_allowin     ),
    .i_is_jal          (is_jal           ),
    .o_pc_load         (pc_load          ),
    .o_fs_valid        (                 ),
    .o_fs_fire         (fs_fire          ),
    .o_ds_valid        (o_ds_valid       ),
    .o_redirect        (redirect         )
  );

  fetch_pc #(
    .PC_RESETVAL       (PC_RESETVAL      )
  ) u_pc (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .i_load            (pc_load          ),
    .i_redirect        (redirect         ),  // jump path back from decode
    .i_jal_target      (jal_target       ),
    .o_pc              (fs_pc            ),
    .o_inst_sram_ren   (o_inst_sram_ren  ),
    .o_inst_sram_addr  (o_inst_sram_addr )
  );

  fetch_inst_align u_align (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .i_pc_load         (pc_load          ),
    .i_pc_align        (fs_pc[2]         ),  // half select within the 64-bit word
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_inst            (fs_inst          )
  );

  fetch_ds_reg u_ds_reg (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .i_fs_fire         (fs_fire          ),
    .i_fs_pc           (fs_pc            ),
    .i_fs_inst         (fs_inst          ),
    .o_ds_pc           (o_ds_pc          ),
    .o_ds_inst         (o_ds_inst        )
  );

  // JAL needs no register values so it resolves right in decode
  fetch_jal_unit u_jal (
    .i_ds_pc           (o_ds_pc          ),
    .i_ds_inst         (o_ds_inst        ),
    .o_is_jal          (is_jal           ),
    .o_jal_target      (jal_target       )
  );

endmodule

// File: sim/inst_sram_model.sv
// instruction sram model, 64-bit words with one cycle read latency and a program loader
`timescale 1ns/1ns

module inst_sram_model import fetch_pkg::*; #(
  parameter logic [SRAM_ADDR_WD-1:0] BASE_ADDR   = 64'h8000_0000,
  parameter int unsigned             DEPTH_WORDS = 32
) (
  input  logic                    i_clk,
  input  logic                    i_ren,
  input  logic [SRAM_ADDR_WD-1:0] i_addr,
  output logic [SRAM_DATA_WD-1:0] o_rdata
);

  logic [SRAM_DATA_WD-1:0] mem [DEPTH_WORDS];
  logic [SRAM_ADDR_WD-1:0] offset;       // byte offset from the base
  logic                    in_range;

  assign offset   = i_addr - BASE_ADDR;
  assign in_range = offset < SRAM_ADDR_WD'(DEPTH_WORDS * 8);

  // slot counts 32-bit instructions, odd slots go to the upper half
  task automatic load_inst(input int unsigned slot, input logic [INST_WD-1:0] inst);
    mem[slot / 2][(slot % 2) * INST_WD +: INST_WD] = inst;
  endtask

  // read data lives for one cycle only
  always @(posedge i_clk) begin
    if (i_ren && in_range) begin
      o_rdata <= mem[offset[SRAM_ADDR_WD-1:3]];
    end else begin
      o_rdata <= 'x;  // no read, nothing valid on the bus
    end
  end

endmodule

// File: sim/tb_fetch_frontend.sv
// testbench for the fetch front end with random back-pressure against a reference pc stream
`timescale 1ns/1ns

module tb_fetch_frontend import fetch_pkg::*; ();

  localparam logic [PC_WD-1:0] BASE_PC            = 64'h8000_0000;
  localparam int unsigned      N_INST             = 64;    // 32 sram words
  localparam logic [6:0]       JAL_OPCODE         = 7'b1101111;
  localparam int unsigned      FIRST_VALID_CYCLES = 2;
  localparam int unsigned      N_XFER_STRAIGHT    = 40;    // execute always ready
  localparam int unsigned      N_XFER_TOTAL       = 400;
  localparam int unsigned      LONG_STALL         = 12;    // cycles a JAL sits in decode
  localparam int unsigned      MAX_LONG_STALLS    = 8;
  localparam int unsigned      MIN_LONG_STALLS    = 3;
  localparam int unsigned      RUN_TIMEOUT        = 20000;

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_es_allowin;
  logic                    o_ds_valid;
  logic [PC_WD-1:0]        o_ds_pc;
  logic [INST_WD-1:0]      o_ds_inst;
  logic                    o_inst_sram_ren;
  logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr;
  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata;

  logic [INST_WD-1:0]      prog [N_INST];   // reference copy of the program
  logic [PC_WD-1:0]        exp_pc;          // pc of the next expected transfer
  int unsigned             n_xfer;
  logic                    held;            // decode was stalled at the last edge
  logic [PC_WD-1:0]        held_pc;
  logic [INST_WD-1:0]      held_inst;
  integer                  seed;

  fetch_frontend_top #(
    .PC_RESETVAL       (BASE_PC          )
  ) u_dut (
    .i_clk             (i_clk            ),
    .i_rst_n           (i_rst_n          ),
    .i_es_allowin      (i_es_allowin     ),
    .o_ds_valid        (o_ds_valid       ),
    .o_ds_pc           (o_ds_pc          ),
    .o_ds_inst         (o_ds_inst        ),
    .o_inst_sram_ren   (o_inst_sram_ren  ),
    .o_inst_sram_addr  (o_inst_sram_addr ),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  inst_sram_model #(
    .BASE_ADDR         (BASE_PC          ),
    .DEPTH_WORDS       (N_INST / 2       )
  ) u_sram (
    .i_clk             (i_clk            ),
    .i_ren             (o_inst_sram_ren  ),
    .i_addr            (o_inst_sram_addr ),
    .o_rdata           (i_inst_sram_rdata)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #10 i_clk = ~i_clk;
    end
  end

  // non-jump addi carrying the slot number in its upper bits
  function automatic logic [INST_WD-1:0] fill_inst(input int unsigned slot);
    return {25'(slot * 257 + 3), 7'b0010011};
  endfunction

  // J-type encoding with rd = x1
  function automatic logic [INST_WD-1:0] jal_inst(input int from_slot, input int to_slot);
    logic [20:0] off;
    off = 21'((to_slot - from_slot) * 4);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, JAL_OPCODE};
  endfunction

  // expected successor of pc in program order
  function automatic logic [PC_WD-1:0] next_pc(input logic [PC_WD-1:0] pc,
                                               input logic [INST_WD-1:0] inst);
    logic [PC_WD-1:0] imm;
    if (inst[6:0] != JAL_OPCODE) begin
      return pc + 64'd4;
    end
    imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    return pc + imm;
  endfunction

  function automatic logic in_program(input logic [PC_WD-1:0] addr);
    return (addr >= BASE_PC) && (addr < BASE_PC + N_INST * 4);
  endfunction

  function automatic logic [INST_WD-1:0] inst_at(input logic [PC_WD-1:0] pc);
    return prog[(pc - BASE_PC) >> 2];
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_with_failure($sformatf("ERROR at %0t ns: %s expected %h actual %h",
                                $time, sig, expected, actual));
  endtask

  // loop of 20 insts with forward and backward JALs in both halves
  task automatic load_program();
    int unsigned s;
    for (s = 0; s < N_INST; s++) begin
      prog[s] = fill_inst(s);
    end
    prog[6]  = jal_inst(6, 20);    // lower half, forward
    prog[14] = jal_inst(14, 17);   // lower half, lands in an upper half
    prog[25] = jal_inst(25, 40);   // upper half, forward
    prog[41] = jal_inst(41, 44);
    prog[47] = jal_inst(47, 10);   // backward, closes the loop
    for (s = 0; s < N_INST; s++) begin
      u_sram.load_inst(s, prog[s]);
    end
  endtask

  // checker sees the values that were stable before each rising edge
  always @(posedge i_clk) begin
    logic [INST_WD-1:0] exp_inst;
    if (o_inst_sram_ren) begin
      assert (o_inst_sram_addr[2:0] == 3'b000)
      else report_mismatch("o_inst_sram_addr[2:0]", 0, o_inst_sram_addr[2:0]);
      assert (in_program(o_inst_sram_addr))
      else stop_with_failure("the DUT read the SRAM outside the loaded program");
    end
    if (i_rst_n) begin
      if (held) begin
        assert (o_ds_valid === 1'b1) else report_mismatch("o_ds_valid", 1, o_ds_valid);
        assert (o_ds_pc === held_pc) else report_mismatch("o_ds_pc", held_pc, o_ds_pc);
        assert (o_ds_inst === held_inst) else report_mismatch("o_ds_inst", held_inst, o_ds_inst);
      end
      held      = o_ds_valid && !i_es_allowin;
      held_pc   = o_ds_pc;
      held_inst = o_ds_inst;
      if (o_ds_valid && i_es_allowin) begin
        assert (in_program(exp_pc))
        else stop_with_failure("the reference pc left the loaded program");
        exp_inst = inst_at(exp_pc);
        assert (o_ds_pc === exp_pc) else report_mismatch("o_ds_pc", exp_pc, o_ds_pc);
        assert (o_ds_inst === exp_inst) else report_mismatch("o_ds_inst", exp_inst, o_ds_inst);
        exp_pc = next_pc(exp_pc, exp_inst);
        n_xfer++;
      end
    end
  end

  initial begin
    int unsigned      cycles;
    logic [31:0]      rnd;
    int unsigned      stall_left;
    int unsigned      stall_reads;     // sram reads seen while a JAL is held
    int unsigned      n_long_stalls;
    logic [PC_WD-1:0] last_stall_pc;

    i_rst_n       = 1'b0;
    i_es_allowin  = 1'b1;
    seed          = 32'h773;
    exp_pc        = BASE_PC;
    n_xfer        = 0;
    held          = 1'b0;
    stall_left    = 0;
    stall_reads   = 0;
    n_long_stalls = 0;
    last_stall_pc = '1;
    load_program();

    @(posedge i_clk);  // first reset edge
    repeat (5) begin
      @(negedge i_clk);
      assert (!o_inst_sram_ren) else report_mismatch("o_inst_sram_ren", 0, o_inst_sram_ren);
      assert (!o_ds_valid) else report_mismatch("o_ds_valid", 0, o_ds_valid);
    end
    i_rst_n = 1'b1;  // outputs checked above hold until the next rising edge

    // first cycle out of reset and then two cycles through fetch and decode
    @(negedge i_clk);
    cycles = 0;
    while (!o_ds_valid) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > 10) begin
        stop_with_failure("timeout waiting for the first decode valid after reset");
      end
    end
    assert (cycles == FIRST_VALID_CYCLES)
    else report_mismatch("o_ds_valid latency", FIRST_VALID_CYCLES, cycles);

    cycles = 0;
    while (n_xfer < N_XFER_STRAIGHT) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        stop_with_failure("timeout in the run with the execute stage always ready");
      end
    end

    // random back-pressure with some JALs held in decode for a long time
    cycles = 0;
    while (n_xfer < N_XFER_TOTAL) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        stop_with_failure("timeout in the run with random back-pressure");
      end
      if (stall_left > 0) begin
        stall_left--;
        if (o_inst_sram_ren) begin
          stall_reads++;
        end
        i_es_allowin = 1'b0;
        if (stall_left == 0) begin
          assert (stall_reads == 1)
          else report_mismatch("o_inst_sram_ren cycles during JAL stall", 1, stall_reads);
        end
      end else if (o_ds_valid && o_ds_inst[6:0] == JAL_OPCODE && o_ds_pc != last_stall_pc &&
                   n_long_stalls < MAX_LONG_STALLS) begin
        stall_left    = LONG_STALL - 1;
        stall_reads   = o_inst_sram_ren ? 1 : 0;  // the redirect read
        last_stall_pc = o_ds_pc;
        n_long_stalls++;
        i_es_allowin  = 1'b0;
      end else begin
        rnd          = $random(seed);
        i_es_allowin = (rnd[1:0] != 2'b00);  // ready 3 cycles in 4
      end
    end

    if (n_long_stalls < MIN_LONG_STALLS) begin
      stop_with_failure("too few JALs were held in decode by a long stall");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: vlog.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/fetch_pc.sv
hw/fetch_inst_align.sv
hw/fetch_ds_reg.sv
hw/fetch_jal_unit.sv
hw/fetch_frontend_top.sv
sim/inst_sram_model.sv
sim/tb_fetch_frontend.sv
